/* tb.f */
+incdir+design
design/cpu_pkg.sv
design/mem_bus_if.sv
design/cpu_memory.sv
design/reg_file.sv
design/alu.sv
design/control_unit.sv
design/cpu_top.sv
tests/cpu_props.sv
tests/cpu_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: all build run clean

all: run

build:
	verilator --binary --timing --assert -f tb.f --top-module cpu_tb -Mdir obj_dir -o cpu_sim

run: build
	./obj_dir/cpu_sim | tee $(LOG)
	grep -qx "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/cpu_tb.sv */
// Accumulator CPU testbench with program loader, ISA reference model and memory compare
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_tb;
    import cpu_pkg::*;

    logic   clk;
    logic   reset;
    logic   en;
    logic   halt;
    count_t cc;
    logic   prog_we;
    word_t  prog_addr;
    word_t  prog_wdata;
    word_t  prog_rdata;

    word_t  img [256];        // Image loaded into the DUT
    word_t  model_mem [256];  // Expected memory after the run
    word_t  wp;               // Program emit pointer
    integer seed;
    int     errors;
    int     tests_run;
    int     tests_failed;

    cpu_top u_dut (
        .clk(clk), .reset(reset), .en(en), .halt(halt), .cc(cc),
        .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_wdata(prog_wdata), .prog_rdata(prog_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t ins(opcode_e op, logic [1:0] a, logic [1:0] b);
        return {op, a, b};
    endfunction

    function automatic word_t ins4(opcode_e op, logic [3:0] n);
        return {op, n};
    endfunction

    // ISA reference that runs model_mem from the reset PC and returns the retired count
    function automatic count_t run_model();
        word_t      r [4];
        word_t      pc;
        word_t      ir;
        word_t      t;
        count_t     n;
        opcode_e    op;
        logic [3:0] lo;
        pc = word_t'(`CPU_RESET_PC);
        n  = '0;
        for (int i = 0; i < 4; i++) begin
            r[i] = '0;
        end
        for (int step = 0; step < 2000; step++) begin
            ir = model_mem[pc];
            op = opcode_e'(ir[7:4]);
            lo = ir[3:0];
            n  = n + count_t'(1);
            t  = pc + 8'd1;
            case (op)
                SYS:   if (lo == HALT) return n;
                ADD:   r[0] = r[lo[3:2]] + r[lo[1:0]];
                SUB:   r[0] = r[lo[3:2]] - r[lo[1:0]];
                NEG:   r[0] = 8'd0 - r[lo[3:2]];
                ADDI:  r[lo[3:2]] = r[lo[3:2]] + {6'b0, lo[1:0]};
                LOADI: r[lo[3:2]] = {6'b0, lo[1:0]};
                MOVE:  r[lo[3:2]] = r[lo[1:0]];
                STORE: model_mem[r[lo[3:2]]] = r[lo[1:0]];
                LOAD:  r[0] = model_mem[{2'b00, r[3][1:0], lo}];
                BGEZ0, BGEZ1: if (!r[0][7]) t = {2'b00, ir[4], lo, 1'b0};
                JUMP: begin
                    t    = r[lo[3:2]];
                    r[3] = pc + 8'd1;
                end
                default: ;
            endcase
            pc = t;
        end
        return n;
    endfunction

    task automatic check_byte(input word_t got, input word_t exp, input int addr);
        if (got !== exp) begin
            $display("ERROR %0t: mem[%0d] is %h, expected %h", $time, addr, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input count_t got, input count_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: cc is %0d, expected %0d", $time, got, exp);
            errors++;
        end
    endtask

    // Address-dependent fill with a random table at 0..11 and constants at 12..15
    task automatic fill_image();
        for (int a = 0; a < 256; a++) begin
            img[a] = word_t'((a * 37) ^ 8'h6c);
        end
        for (int a = 0; a < 12; a++) begin
            img[a] = word_t'($random(seed));
        end
        img[12] = 8'd56;   // JUMP target
        img[13] = 8'd5;    // Positive r0
        img[14] = 8'h80;   // Negative r0
        img[15] = 8'd200;  // Store pointer
        wp = word_t'(`CPU_RESET_PC);
    endtask

    task automatic emit(input word_t b);
        img[wp] = b;
        wp = wp + 8'd1;
    endtask

    task automatic emit_ptr_setup();
        emit(ins4(LOAD, 4'd15));
        emit(ins(MOVE, 2'd2, 2'd0));
    endtask

    task automatic emit_store_r0();
        emit(ins(STORE, 2'd2, 2'd0));
        emit(ins(ADDI, 2'd2, 2'd1));
    endtask

    task automatic gen_alu(input int nops);
        logic [31:0] r;
        emit_ptr_setup();
        for (int i = 0; i < nops; i++) begin
            r = $random(seed);
            case (r[31:8] % 6)
                0: begin
                    emit(ins4(LOAD, r[3:0] % 4'd12));
                    emit(ins(MOVE, 2'd1, 2'd0));
                end
                1: begin
                    emit(ins(LOADI, {1'b0, r[0]}, r[2:1]));
                    emit(ins(ADDI, {1'b0, r[0]}, r[4:3]));
                end
                2: emit(ins(ADD, {1'b0, r[0]}, r[2:1]));
                3: emit(ins(SUB, {1'b0, r[0]}, r[2:1]));
                4: emit(ins(NEG, {1'b0, r[0]}, 2'd0));
                default: emit(ins(MOVE, 2'd1, r[2:1]));
            endcase
            emit_store_r0();
        end
        emit(ins4(SYS, HALT));
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        en    <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic load_image();
        for (int a = 0; a < 256; a++) begin
            @(posedge clk);
            prog_we    <= 1'b1;
            prog_addr  <= word_t'(a);
            prog_wdata <= img[a];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic check_memory();
        for (int a = 0; a < 256; a++) begin
            @(posedge clk);
            prog_addr <= word_t'(a);
            @(negedge clk);
            check_byte(prog_rdata, model_mem[a], a);
        end
    endtask

    task automatic wait_halt(output logic done);
        done = 1'b0;
        for (int c = 0; c < 2000 && !done; c++) begin
            @(negedge clk);
            done = halt;
        end
    endtask

    task automatic run_test(input string name, input logic hold_check);
        count_t exp_cc;
        logic   done;
        int     errs0;
        errs0 = errors;
        for (int a = 0; a < 256; a++) begin
            model_mem[a] = img[a];
        end
        exp_cc = run_model();
        apply_reset();
        load_image();
        @(posedge clk);
        en <= 1'b1;
        wait_halt(done);
        if (!done) begin
            $display("Timeout: %s did not reach HALT within 2000 cycles", name);
            errors++;
        end else begin
            check_count(cc, exp_cc);
            check_memory();
            if (hold_check) begin
                for (int i = 0; i < 20; i++) begin
                    @(posedge clk);
                    en <= ~en;  // Pulses on a halted core
                end
                @(negedge clk);
                if (halt !== 1'b1) begin
                    $display("ERROR %0t: halt is %b after en pulses, expected 1", $time, halt);
                    errors++;
                end
                check_count(cc, exp_cc);
                check_memory();
            end
        end
        @(posedge clk);
        en <= 1'b0;
        tests_run++;
        if (errors != errs0) begin
            tests_failed++;
        end
        $display("%-8s %s", name, (errors == errs0) ? "passed" : "failed");
    endtask

    initial begin
        reset      <= 1'b1;
        en         <= 1'b0;
        prog_we    <= 1'b0;
        prog_addr  <= '0;
        prog_wdata <= '0;
        seed         = 32'h1cc4_a0f7;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;

        fill_image();
        gen_alu(24);
        run_test("alu", 1'b0);

        // Every rd/rs pair stores rs at the small address left in rd
        fill_image();
        for (int d = 0; d < 4; d++) begin
            for (int s = 0; s < 4; s++) begin
                logic [31:0] r;
                r = $random(seed);
                emit(ins(LOADI, 2'(s), r[1:0]));
                emit(ins(ADDI, 2'(s), r[3:2]));
                emit(ins(MOVE, 2'(d), 2'(s)));
                emit(ins(ADDI, 2'(d), r[5:4]));
                emit(ins(STORE, 2'(d), 2'(s)));
            end
        end
        emit(ins4(SYS, HALT));
        run_test("moves", 1'b0);

        fill_image();
        emit_ptr_setup();
        for (int k = 0; k < 12; k++) begin
            logic [31:0] r;
            r = $random(seed);
            emit(ins(LOADI, 2'd3, r[1:0]));
            emit(ins4(LOAD, r[5:2]));
            emit_store_r0();
        end
        emit(ins4(SYS, HALT));
        run_test("load", 1'b0);

        // Taken paths land at 50 (BGEZ1) and 20 (BGEZ0) and markers 1 and 2 show the path
        fill_image();
        emit_ptr_setup();
        emit(ins4(LOAD, 4'd14));
        emit(ins4(BGEZ1, 4'd9));
        emit(ins(LOADI, 2'd1, 2'd1));
        emit(ins(STORE, 2'd2, 2'd1));
        emit(ins(ADDI, 2'd2, 2'd1));
        emit(ins4(LOAD, 4'd13));
        emit(ins4(BGEZ1, 4'd9));
        emit(ins(LOADI, 2'd1, 2'd3));
        emit(ins(STORE, 2'd2, 2'd1));
        emit(ins4(SYS, HALT));
        wp = 8'd50;
        emit(ins(LOADI, 2'd1, 2'd2));
        emit(ins(STORE, 2'd2, 2'd1));
        emit(ins(ADDI, 2'd2, 2'd1));
        emit(ins4(LOAD, 4'd14));
        emit(ins4(BGEZ0, 4'd10));
        emit(ins(LOADI, 2'd1, 2'd1));
        emit(ins(STORE, 2'd2, 2'd1));
        emit(ins(ADDI, 2'd2, 2'd1));
        emit(ins4(LOAD, 4'd13));
        emit(ins4(BGEZ0, 4'd10));
        emit(ins4(SYS, HALT));
        wp = 8'd20;
        emit(ins(LOADI, 2'd1, 2'd2));
        emit(ins(STORE, 2'd2, 2'd1));
        emit(ins4(SYS, HALT));
        run_test("bgez", 1'b0);

        // JUMP through r1 to 56, then store the return address from r3
        fill_image();
        emit_ptr_setup();
        emit(ins4(LOAD, 4'd12));
        emit(ins(MOVE, 2'd1, 2'd0));
        emit(ins(JUMP, 2'd1, 2'd0));
        wp = 8'd56;
        emit(ins(STORE, 2'd2, 2'd3));
        emit(ins(ADDI, 2'd2, 2'd1));
        emit(ins(LOADI, 2'd1, 2'd3));
        emit(ins(STORE, 2'd2, 2'd1));
        emit(ins4(SYS, HALT));
        run_test("jump", 1'b0);

        fill_image();
        gen_alu(16);
        run_test("halt", 1'b1);

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tests/cpu_props.sv */
// Controller assertions for sticky halt, a quiet bus when halted and memory ready timing
`timescale 1ns/1ps

module cpu_props (
    input logic                  clk,
    input logic                  reset,
    input logic                  halt,
    input cpu_pkg::ctrl_state_e  state,
    input logic                  req,
    input logic                  ready
);
    import cpu_pkg::*;

    halt_sticky: assert property (@(posedge clk) disable iff (reset) halt |=> halt)
        else $error("halt dropped without reset");

    // No fetch or data access once parked
    halted_no_req: assert property (@(posedge clk) disable iff (reset)
        (state == HALTED) |-> !req)
        else $error("memory request raised in HALTED");

    req_then_ready: assert property (@(posedge clk) disable iff (reset) req |=> ready)
        else $error("ready missing one cycle after req");

    reset_clears_halt: assert property (@(posedge clk) reset |=> !halt)
        else $error("halt high after reset");

endmodule

bind control_unit cpu_props u_props (
    .clk(clk), .reset(reset), .halt(halt), .state(state),
    .req(mem.req), .ready(mem.ready)
);

/* design/cpu_top.sv */
// Accumulator CPU top level joining controller, registers, ALU and memory
`timescale 1ns/1ps

module cpu_top (
    input  logic            clk,
    input  logic            reset,
    input  logic            en,
    output logic            halt,
    output cpu_pkg::count_t cc,
    input  logic            prog_we,
    input  cpu_pkg::word_t  prog_addr,
    input  cpu_pkg::word_t  prog_wdata,
    output cpu_pkg::word_t  prog_rdata
);
    import cpu_pkg::*;

    reg_sel_t rd_sel, rs_sel, wr_sel;
    word_t    rd_val, rs_val, r0_val, r3_val;
    word_t    wr_data;
    word_t    alu_result;
    alu_op_e  alu_op;
    logic     wr_en;
    logic     core_idle;

    mem_bus_if bus ();

    control_unit u_ctrl (
        .clk(clk), .reset(reset), .en(en),
        .mem(bus.ctrl),
        .rd_sel(rd_sel), .rs_sel(rs_sel),
        .rd_val(rd_val), .rs_val(rs_val), .r0_val(r0_val), .r3_val(r3_val),
        .alu_op(alu_op), .alu_result(alu_result),
        .wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data),
        .core_idle(core_idle), .halt(halt), .cc(cc)
    );

    reg_file u_regs (
        .clk(clk), .reset(reset),
        .rd_sel(rd_sel), .rs_sel(rs_sel), .wr_sel(wr_sel),
        .wr_en(wr_en), .wr_data(wr_data),
        .rd_val(rd_val), .rs_val(rs_val), .r0_val(r0_val), .r3_val(r3_val)
    );

    alu u_alu (
        .op(alu_op), .a(rd_val), .b(rs_val), .result(alu_result)
    );

    cpu_memory u_mem (
        .clk(clk),
        .bus(bus.mem),
        .core_idle(core_idle),
        .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_wdata(prog_wdata), .prog_rdata(prog_rdata)
    );

endmodule

/* design/control_unit.sv */
// Fetch and execute FSM with PC, instruction register, retired count and halt
`timescale 1ns/1ps
`include "cpu_macros.svh"

module control_unit (
    input  logic               clk,
    input  logic               reset,
    input  logic               en,
    mem_bus_if.ctrl            mem,
    output cpu_pkg::reg_sel_t  rd_sel,
    output cpu_pkg::reg_sel_t  rs_sel,
    input  cpu_pkg::word_t     rd_val,
    input  cpu_pkg::word_t     rs_val,
    input  cpu_pkg::word_t     r0_val,
    input  cpu_pkg::word_t     r3_val,
    output cpu_pkg::alu_op_e   alu_op,
    input  cpu_pkg::word_t     alu_result,
    output logic               wr_en,
    output cpu_pkg::reg_sel_t  wr_sel,
    output cpu_pkg::word_t     wr_data,
    output logic               core_idle,
    output logic               halt,
    output cpu_pkg::count_t    cc
);
    import cpu_pkg::*;

    ctrl_state_e state;
    ctrl_state_e next_state;
    word_t       pc;
    word_t       pc_next;
    word_t       pc_inc;
    word_t       ir;
    word_t       imm;
    word_t       br_target;
    word_t       ld_addr;
    opcode_e     op;
    sys_e        sys;
    logic        retire;

    // Instruction fields
    assign op     = opcode_e'(ir[7:4]);
    assign sys    = sys_e'(ir[3:0]);
    assign rd_sel = ir[3:2];
    assign rs_sel = ir[1:0];
    assign imm    = {6'b0, ir[1:0]};

    assign pc_inc    = pc + word_t'(1);
    assign br_target = {`CPU_BR_PAGE, ir[4], ir[3:0], 1'b0};
    assign ld_addr   = {2'b00, r3_val[1:0], ir[3:0]};

    assign core_idle = (state == IDLE) || (state == HALTED);

    always_comb begin
        case (op)
            SUB:     alu_op = ALU_SUB;
            NEG:     alu_op = ALU_NEG;
            default: alu_op = ALU_ADD;
        endcase
    end

    // Memory strobes for fetch and for STORE/LOAD
    always_comb begin
        mem.req   = 1'b0;
        mem.we    = 1'b0;
        mem.addr  = pc;
        mem.wdata = rs_val;
        case (state)
            FETCH: mem.req = 1'b1;
            EXECUTE: begin
                if (op == STORE) begin
                    mem.req  = 1'b1;
                    mem.we   = 1'b1;
                    mem.addr = rd_val;  // mem[rd] = rs
                end else if (op == LOAD) begin
                    mem.req  = 1'b1;
                    mem.addr = ld_addr;
                end
            end
            default: ;
        endcase
    end

    // Register write-back source
    always_comb begin
        wr_en   = 1'b0;
        wr_sel  = rd_sel;
        wr_data = rs_val;
        if (state == EXECUTE) begin
            case (op)
                ADD, SUB, NEG: begin
                    wr_en   = 1'b1;
                    wr_sel  = 2'd0;
                    wr_data = alu_result;
                end
                ADDI: begin
                    wr_en   = 1'b1;
                    wr_data = rd_val + imm;
                end
                LOADI: begin
                    wr_en   = 1'b1;
                    wr_data = imm;
                end
                MOVE: wr_en = 1'b1;
                JUMP: begin
                    wr_en   = 1'b1;
                    wr_sel  = 2'd3;  // Return address
                    wr_data = pc_inc;
                end
                default: ;
            endcase
        end else if (state == MEM_WAIT && op == LOAD && mem.ready) begin
            wr_en   = 1'b1;
            wr_sel  = 2'd0;
            wr_data = mem.rdata;
        end
    end

    always_comb begin
        next_state = state;
        pc_next    = pc;
        retire     = 1'b0;
        case (state)
            IDLE: if (en) next_state = FETCH;
            FETCH: next_state = FETCH_WAIT;
            FETCH_WAIT: if (mem.ready) next_state = EXECUTE;
            EXECUTE: begin
                next_state = FETCH;
                pc_next    = pc_inc;
                retire     = 1'b1;
                case (op)
                    SYS: begin
                        if (sys == HALT) begin
                            next_state = HALTED;
                            pc_next    = pc;
                        end
                    end
                    BGEZ0, BGEZ1: if (!r0_val[7]) pc_next = br_target;
                    JUMP: pc_next = rd_val;  // Old rd value before r3 is overwritten
                    STORE, LOAD: begin
                        next_state = MEM_WAIT;
                        pc_next    = pc;
                        retire     = 1'b0;
                    end
                    default: ;  // Undefined opcodes behave as NOP
                endcase
            end
            MEM_WAIT: begin
                if (mem.ready) begin
                    next_state = FETCH;
                    pc_next    = pc_inc;
                    retire     = 1'b1;
                end
            end
            HALTED: ;  // Only reset leaves
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            pc    <= word_t'(`CPU_RESET_PC);
            cc    <= '0;
            halt  <= 1'b0;
        end else begin
            state <= next_state;
            pc    <= pc_next;
            if (retire) begin
                cc <= cc + count_t'(1);
            end
            if (next_state == HALTED) begin
                halt <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_WAIT && mem.ready) begin
            ir <= mem.rdata;
        end
    end

endmodule

/* design/alu.sv */
// Accumulator ALU producing the new r0 from add, subtract or negate
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_e op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   result
);
    import cpu_pkg::*;

    // a is the rd register, b the rs register, all modulo 256
    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_NEG: result = word_t'(0) - a;
            default: result = a + b;
        endcase
    end

endmodule

/* design/reg_file.sv */
// Four user registers r0 to r3 with two indexed read ports and one write port
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::reg_sel_t rd_sel,
    input  cpu_pkg::reg_sel_t rs_sel,
    input  cpu_pkg::reg_sel_t wr_sel,
    input  logic              wr_en,
    input  cpu_pkg::word_t    wr_data,
    output cpu_pkg::word_t    rd_val,
    output cpu_pkg::word_t    rs_val,
    output cpu_pkg::word_t    r0_val,
    output cpu_pkg::word_t    r3_val
);
    import cpu_pkg::*;

    word_t regs [4];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_sel] <= wr_data;
        end
    end

    assign rd_val = regs[rd_sel];
    assign rs_val = regs[rs_sel];

    // Fixed taps for the branch test and the LOAD address
    assign r0_val = regs[0];
    assign r3_val = regs[3];

endmodule

/* design/cpu_memory.sv */
// Single-port code and data RAM with one-cycle ready and a program loader port
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_memory (
    input  logic           clk,
    mem_bus_if.mem         bus,
    input  logic           core_idle,
    input  logic           prog_we,
    input  cpu_pkg::word_t prog_addr,
    input  cpu_pkg::word_t prog_wdata,
    output cpu_pkg::word_t prog_rdata
);
    import cpu_pkg::*;

    word_t ram [`CPU_MEM_DEPTH];

    logic load_we;

    // Loader only gets the port while the core is parked
    assign load_we = core_idle && prog_we;

    always_ff @(posedge clk) begin
        if (bus.req && bus.we) begin
            ram[bus.addr] <= bus.wdata;
        end else if (load_we) begin
            ram[prog_addr] <= prog_wdata;
        end
    end

    // Read data is registered and lands one cycle after the strobe
    always_ff @(posedge clk) begin
        bus.ready <= bus.req;
        if (bus.req) begin
            bus.rdata <= ram[bus.addr];
        end
    end

    assign prog_rdata = ram[prog_addr];  // Readback for the loader

endmodule

/* design/mem_bus_if.sv */
// Memory request bus between the controller and the byte RAM
`timescale 1ns/1ps

interface mem_bus_if;
    import cpu_pkg::*;

    logic  req;    // One-cycle strobe
    logic  we;
    word_t addr;
    word_t wdata;
    word_t rdata;  // Valid with ready on reads
    logic  ready;  // Pulses one cycle after req

    modport ctrl (
        output req, we, addr, wdata,
        input  rdata, ready
    );

    modport mem (
        input  req, we, addr, wdata,
        output rdata, ready
    );

endinterface

/* design/cpu_pkg.sv */
// Accumulator CPU shared types for data, opcodes, ALU operations and FSM states
`include "cpu_macros.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_W-1:0] word_t;
    typedef logic [`CPU_CC_W-1:0]   count_t;
    typedef logic [1:0]             reg_sel_t;

    // Upper nibble of the instruction
    typedef enum logic [3:0] {
        SYS   = 4'b0000,
        ADD   = 4'b0001,
        ADDI  = 4'b0010,
        SUB   = 4'b0011,
        NEG   = 4'b0110,
        BGEZ0 = 4'b1000,
        BGEZ1 = 4'b1001,
        MOVE  = 4'b1010,
        STORE = 4'b1011,
        LOAD  = 4'b1100,
        LOADI = 4'b1101,
        JUMP  = 4'b1110
    } opcode_e;

    // Lower nibble when the opcode is SYS
    typedef enum logic [3:0] {
        NOP  = 4'b0000,
        HALT = 4'b1111
    } sys_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_NEG = 2'd2
    } alu_op_e;

    typedef enum logic [2:0] {
        IDLE, FETCH, FETCH_WAIT, EXECUTE, MEM_WAIT, HALTED
    } ctrl_state_e;

endpackage

/* design/cpu_macros.svh */
// Accumulator CPU macros for datapath widths, memory size and reset address
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data and address width
`define CPU_WORD_W 8

// Retired instruction counter width
`define CPU_CC_W 16

// Unified code and data memory, in bytes
`define CPU_MEM_DEPTH 256

// First fetch address after reset
`define CPU_RESET_PC 33

// Upper page bits of a branch target, above the opcode's low bit
`define CPU_BR_PAGE 2'b00

`endif
